// File: Makefile
# Verilator build and run of the peripheral subsystem testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_soc_periph \
		-f filelist.f --Mdir obj_dir -o tb_soc_periph
	-./obj_dir/tb_soc_periph > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "=== PASS ===" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

// File: filelist.f
rtl/soc_bus_pkg.sv
rtl/soc_irq_pkg.sv
rtl/bus_addr_decode.sv
rtl/scratch_ram.sv
rtl/clint_regs.sv
rtl/plic_regs.sv
rtl/bus_resp_merge.sv
rtl/soc_periph_top.sv
testbench/soc_periph_props.sv
testbench/tb_soc_periph.sv

// File: rtl/bus_addr_decode.sv
// ====================
// Pipeline stage 1: address decode
// Registers each incoming request and tags it with the target picked
// from the memory map. The only place the map is evaluated.
// ====================

`timescale 1ns/1ps

module bus_addr_decode (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  req_valid_i,
    input  soc_bus_pkg::bus_req_t req_i,
    output logic                  dec_valid_o,
    output soc_bus_pkg::dec_req_t dec_req_o
);
    import soc_bus_pkg::*;

    bus_tgt_e tgt;

    // Inclusive range test on the offset from base
    function automatic logic in_range(input logic [31:0] addr,
                                      input logic [31:0] base,
                                      input logic [31:0] last);
        return (addr - base) <= (last - base);
    endfunction

    // Map lookup
    always_comb begin
        if (in_range(req_i.addr, RAM_BASE, RAM_LAST)) begin
            tgt = TGT_RAM;
        end else if (in_range(req_i.addr, CLINT_BASE, CLINT_LAST)) begin
            tgt = TGT_CLINT;
        end else if (in_range(req_i.addr, PLIC_BASE, PLIC_LAST)) begin
            tgt = TGT_PLIC;
        end else begin
            // Unmapped addresses get err from the merge stage
            tgt = TGT_NONE;
        end
    end

    // Valid bit
    always_ff @(posedge clk) begin
        if (rst_i) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= req_valid_i;
        end
    end

    // Request payload and its target tag
    always_ff @(posedge clk) begin
        dec_req_o.req <= req_i;
        dec_req_o.tgt <= tgt;
    end

endmodule

// File: rtl/bus_resp_merge.sv
// ====================
// Pipeline stage 3: response merge
// Delays the target tag by one stage, then picks that target's read
// data and registers the response. Unmapped accesses get err.
// ====================

`timescale 1ns/1ps

module bus_resp_merge (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   dec_valid_i,
    input  soc_bus_pkg::bus_tgt_e  dec_tgt_i,
    input  logic [31:0]            ram_rdata_i,
    input  logic [31:0]            clint_rdata_i,
    input  logic [31:0]            plic_rdata_i,
    output logic                   resp_valid_o,
    output soc_bus_pkg::bus_resp_t resp_o
);
    import soc_bus_pkg::*;

    logic      valid_q;
    bus_tgt_e  tgt_q;
    bus_resp_t resp_d;

    // Tag lines up with the targets' registered rdata
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= dec_valid_i;
        end
        tgt_q <= dec_tgt_i;
    end

    // Select by tag only
    always_comb begin
        resp_d = '0;
        case (tgt_q)
            TGT_RAM:   resp_d.rdata = ram_rdata_i;
            TGT_CLINT: resp_d.rdata = clint_rdata_i;
            TGT_PLIC:  resp_d.rdata = plic_rdata_i;
            default:   resp_d.err   = valid_q;
        endcase
    end

    // Response strobe, one cycle per request
    always_ff @(posedge clk) begin
        if (rst_i) begin
            resp_valid_o <= 1'b0;
            resp_o       <= '0;
        end else begin
            resp_valid_o <= valid_q;
            resp_o       <= resp_d;
        end
    end

endmodule

// File: rtl/clint_regs.sv
// ====================
// Pipeline stage 2: CLINT target
// Free-running 64-bit mtime, a 32-bit mtimecmp and the msip bit.
// Drives the machine timer and software interrupt lines.
// ====================

`timescale 1ns/1ps

module clint_regs (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  dec_valid_i,
    input  soc_bus_pkg::dec_req_t dec_req_i,
    output logic [31:0]           rdata_o,
    output logic                  timer_irq_o,
    output logic                  soft_irq_o
);
    import soc_bus_pkg::*;
    import soc_irq_pkg::*;

    logic [63:0] mtime_q;
    logic [31:0] mtimecmp_q;
    logic        msip_q;
    logic [15:0] off;
    logic        hit;
    logic        wr;

    // Offset within the CLINT window
    assign off = 16'(dec_req_i.req.addr - CLINT_BASE);
    assign hit = dec_valid_i && (dec_req_i.tgt == TGT_CLINT);
    assign wr  = hit && (dec_req_i.req.op == BUS_WRITE);

    // ====================
    // Registers and interrupts
    // ====================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            mtime_q     <= '0;
            mtimecmp_q  <= '1;
            msip_q      <= 1'b0;
            timer_irq_o <= 1'b0;
            soft_irq_o  <= 1'b0;
        end else begin
            mtime_q <= mtime_q + 64'd1;
            if (wr && (off == CLINT_MSIP)) begin
                msip_q <= dec_req_i.req.wdata[0];
            end
            if (wr && (off == CLINT_MTIMECMP)) begin
                mtimecmp_q <= dec_req_i.req.wdata;
            end
            // Compare is zero-extended, only the low word is mapped
            timer_irq_o <= (mtime_q >= {32'd0, mtimecmp_q});
            soft_irq_o  <= msip_q;
        end
    end

    // Read data, zero for writes and unknown offsets
    always_ff @(posedge clk) begin
        if (hit) begin
            rdata_o <= '0;
            if (dec_req_i.req.op == BUS_READ) begin
                case (off)
                    CLINT_MSIP:     rdata_o <= {31'd0, msip_q};
                    CLINT_MTIMECMP: rdata_o <= mtimecmp_q;
                    CLINT_MTIME:    rdata_o <= mtime_q[31:0];
                    default:        rdata_o <= '0;
                endcase
            end
        end
    end

endmodule

// File: rtl/plic_regs.sv
// ====================
// Pipeline stage 2: PLIC target
// Level-sampled pending latch, enable mask and a claim register that
// clears the claimed source on read. No priorities or thresholds.
// ====================

`timescale 1ns/1ps

module plic_regs #(
    parameter int NUM_IRQS = 5
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  dec_valid_i,
    input  soc_bus_pkg::dec_req_t dec_req_i,
    input  logic [NUM_IRQS-1:0]   irq_i,
    output logic [31:0]           rdata_o,
    output logic                  ext_irq_o
);
    import soc_bus_pkg::*;
    import soc_irq_pkg::*;

    logic [NUM_IRQS-1:0]   pending_q;
    logic [NUM_IRQS-1:0]   enable_q;
    logic [NUM_IRQS-1:0]   active;
    logic [NUM_IRQS-1:0]   claim_mask;
    logic [CLAIM_ID_W-1:0] claim_id;
    logic [15:0]           off;
    logic                  hit;
    logic                  rd;
    logic                  claim;

    assign off    = 16'(dec_req_i.req.addr - PLIC_BASE);
    assign hit    = dec_valid_i && (dec_req_i.tgt == TGT_PLIC);
    assign rd     = hit && (dec_req_i.req.op == BUS_READ);
    assign claim  = rd && (off == PLIC_CLAIM);
    assign active = pending_q & enable_q;

    // Lowest-numbered active source wins, id is index plus one
    always_comb begin
        claim_id   = '0;
        claim_mask = '0;
        for (int i = NUM_IRQS - 1; i >= 0; i--) begin
            if (active[i]) begin
                claim_id      = CLAIM_ID_W'(i + 1);
                claim_mask    = '0;
                claim_mask[i] = 1'b1;
            end
        end
    end

    // ====================
    // Pending and enable
    // ====================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pending_q <= '0;
            enable_q  <= '0;
        end else begin
            // Source still high keeps its bit set through a claim
            pending_q <= (pending_q & ~(claim ? claim_mask : '0)) | irq_i;
            if (hit && (dec_req_i.req.op == BUS_WRITE) && (off == PLIC_ENABLE)) begin
                enable_q <= dec_req_i.req.wdata[NUM_IRQS-1:0];
            end
        end
    end

    // Read data
    always_ff @(posedge clk) begin
        if (hit) begin
            rdata_o <= '0;
            if (rd) begin
                case (off)
                    PLIC_PENDING: rdata_o <= 32'(pending_q);
                    PLIC_ENABLE:  rdata_o <= 32'(enable_q);
                    PLIC_CLAIM:   rdata_o <= 32'(claim_id);
                    default:      rdata_o <= '0;
                endcase
            end
        end
    end

    // Any enabled source pending
    assign ext_irq_o = |active;

endmodule

// File: rtl/scratch_ram.sv
// ====================
// Pipeline stage 2: scratch RAM target
// Word-addressed storage, indexed by address bits 2 and up modulo
// RAM_WORDS, so higher addresses alias onto the same words
// ====================

`timescale 1ns/1ps

module scratch_ram #(
    parameter int RAM_WORDS = 64
) (
    input  logic                  clk,
    input  logic                  dec_valid_i,
    input  soc_bus_pkg::dec_req_t dec_req_i,
    output logic [31:0]           rdata_o
);
    import soc_bus_pkg::*;

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [31:0]      mem [RAM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             hit;

    // Word index with aliasing
    assign idx = IDX_W'(dec_req_i.req.addr[31:2] % RAM_WORDS);
    assign hit = dec_valid_i && (dec_req_i.tgt == TGT_RAM);

    always_ff @(posedge clk) begin
        if (hit) begin
            if (dec_req_i.req.op == BUS_WRITE) begin
                mem[idx] <= dec_req_i.req.wdata;
                // Writes answer with zero data
                rdata_o  <= '0;
            end else begin
                rdata_o  <= mem[idx];
            end
        end
    end

endmodule

// File: rtl/soc_bus_pkg.sv
// ====================
// Shared bus types for the peripheral subsystem
// Request, decoded request and response structs, opcode and target
// enums, and the fixed memory map used by the address decoder
// ====================

package soc_bus_pkg;

    // Single-beat opcode
    typedef enum logic {
        BUS_READ  = 1'b0,
        BUS_WRITE = 1'b1
    } bus_op_e;

    // Decoded target
    typedef enum logic [1:0] {
        TGT_RAM   = 2'd0,
        TGT_CLINT = 2'd1,
        TGT_PLIC  = 2'd2,
        TGT_NONE  = 2'd3
    } bus_tgt_e;

    // Master request, 65 bits
    typedef struct packed {
        bus_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    // Request tagged with its target, 67 bits
    typedef struct packed {
        bus_req_t req;
        bus_tgt_e tgt;
    } dec_req_t;

    // Response to the master, 33 bits
    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } bus_resp_t;

    // ====================
    // Memory map, inclusive bounds
    // ====================
    parameter logic [31:0] RAM_BASE   = 32'h0000_0000;
    parameter logic [31:0] RAM_LAST   = 32'h0000_2FFF;
    parameter logic [31:0] CLINT_BASE = 32'h0000_3000;
    parameter logic [31:0] CLINT_LAST = 32'h0000_EFFF;
    parameter logic [31:0] PLIC_BASE  = 32'h0000_F000;
    parameter logic [31:0] PLIC_LAST  = 32'h0000_FFFF;

endpackage

// File: rtl/soc_irq_pkg.sv
// ====================
// Interrupt controller register layout
// Offset enums for the CLINT and PLIC blocks, taken relative to each
// block's base address, plus the width of the PLIC claim id
// ====================

package soc_irq_pkg;

    // CLINT offsets from CLINT_BASE
    typedef enum logic [15:0] {
        // Bit 0 only
        CLINT_MSIP     = 16'h0000,
        CLINT_MTIMECMP = 16'h0008,
        // Low word of mtime, read-only
        CLINT_MTIME    = 16'h0010
    } clint_reg_e;

    // PLIC offsets from PLIC_BASE
    typedef enum logic [15:0] {
        // Read-only
        PLIC_PENDING = 16'h0000,
        PLIC_ENABLE  = 16'h0004,
        // Read claims and clears
        PLIC_CLAIM   = 16'h0008
    } plic_reg_e;

    // Claim id width, room for up to 63 sources plus the "none" id
    parameter int CLAIM_ID_W = 6;

endpackage

// File: rtl/soc_periph_top.sv
// ====================
// Peripheral subsystem top level
// Decode, three targets (RAM, CLINT, PLIC) and the response merge.
// Fixed three-edge latency, responses in request order.
// ====================

`timescale 1ns/1ps

module soc_periph_top #(
    parameter int NUM_IRQS  = 5,
    parameter int RAM_WORDS = 64
) (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   req_valid_i,
    input  soc_bus_pkg::bus_req_t  req_i,
    input  logic [NUM_IRQS-1:0]    irq_i,
    output logic                   resp_valid_o,
    output soc_bus_pkg::bus_resp_t resp_o,
    output logic                   timer_irq_o,
    output logic                   soft_irq_o,
    output logic                   ext_irq_o
);
    import soc_bus_pkg::*;

    logic        dec_valid;
    dec_req_t    dec_req;
    logic [31:0] ram_rdata;
    logic [31:0] clint_rdata;
    logic [31:0] plic_rdata;

    // ====================
    // Stage 1
    // ====================
    bus_addr_decode decode_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .dec_valid_o (dec_valid),
        .dec_req_o   (dec_req)
    );

    // ====================
    // Stage 2 targets
    // ====================
    scratch_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) ram_i (
        .clk         (clk),
        .dec_valid_i (dec_valid),
        .dec_req_i   (dec_req),
        .rdata_o     (ram_rdata)
    );

    clint_regs clint_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .dec_valid_i (dec_valid),
        .dec_req_i   (dec_req),
        .rdata_o     (clint_rdata),
        .timer_irq_o (timer_irq_o),
        .soft_irq_o  (soft_irq_o)
    );

    plic_regs #(
        .NUM_IRQS (NUM_IRQS)
    ) plic_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .dec_valid_i (dec_valid),
        .dec_req_i   (dec_req),
        .irq_i       (irq_i),
        .rdata_o     (plic_rdata),
        .ext_irq_o   (ext_irq_o)
    );

    // ====================
    // Stage 3
    // ====================
    bus_resp_merge merge_i (
        .clk           (clk),
        .rst_i         (rst_i),
        .dec_valid_i   (dec_valid),
        .dec_tgt_i     (dec_req.tgt),
        .ram_rdata_i   (ram_rdata),
        .clint_rdata_i (clint_rdata),
        .plic_rdata_i  (plic_rdata),
        .resp_valid_o  (resp_valid_o),
        .resp_o        (resp_o)
    );

endmodule

// File: testbench/bus_cases.txt
# R/W addr wdata exp_rdata mask exp_err | I irq_i | C timer soft ext
# Values in hex, rdata compared where mask bits are set
W 00000100 a5a55a5a 00000000 ffffffff 0
R 00000100 00000000 a5a55a5a ffffffff 0
R 00000200 00000000 a5a55a5a ffffffff 0
R 00010000 00000000 00000000 ffffffff 1
W 00010100 deadbeef 00000000 ffffffff 1
R 00000100 00000000 a5a55a5a ffffffff 0
W 00003000 00000001 00000000 ffffffff 0
C 0 1 0
W 00003000 00000000 00000000 ffffffff 0
C 0 0 0
W 00003008 00000000 00000000 ffffffff 0
C 1 0 0
W 00003008 ffffffff 00000000 ffffffff 0
C 0 0 0
R 00003010 00000000 00000000 00000000 0
R 00003010 00000000 00000000 00000000 0
I 0a
I 00
R 0000f000 00000000 0000000a ffffffff 0
C 0 0 0
W 0000f004 0000001f 00000000 ffffffff 0
C 0 0 1
R 0000f008 00000000 00000002 ffffffff 0
R 0000f008 00000000 00000004 ffffffff 0
R 0000f008 00000000 00000000 ffffffff 0
C 0 0 0

// File: testbench/soc_periph_props.sv
// ====================
// Bus timing and reset properties for the peripheral top level
// Bound to the top and evaluated on every rising clock edge
// ====================

`timescale 1ns/1ps

module soc_periph_props (
    input logic                   clk,
    input logic                   rst_i,
    input logic                   req_valid_i,
    input logic                   resp_valid_o,
    input soc_bus_pkg::bus_resp_t resp_o
);

    // Fixed three-edge latency
    resp_follows_req: assert property (@(posedge clk) disable iff (rst_i)
        req_valid_i |-> ##3 resp_valid_o)
        else $error("resp_valid_o missing three edges after req_valid_i");

    // No response without a request
    resp_has_req: assert property (@(posedge clk) disable iff (rst_i)
        resp_valid_o |-> $past(req_valid_i, 3))
        else $error("resp_valid_o without a request three edges earlier");

    // Quiet bus after reset
    quiet_after_reset: assert property (@(posedge clk) rst_i |=> !resp_valid_o)
        else $error("resp_valid_o high in the cycle after reset");

    // err only on a response
    err_needs_valid: assert property (@(posedge clk) disable iff (rst_i)
        resp_o.err |-> resp_valid_o)
        else $error("resp_o.err high without resp_valid_o");

endmodule

bind soc_periph_top soc_periph_props props_i (
    .clk          (clk),
    .rst_i        (rst_i),
    .req_valid_i  (req_valid_i),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o)
);

// File: testbench/tb_soc_periph.sv
// ====================
// Testbench for the peripheral subsystem top level
// Runs the directed cases from the case file, then a back-to-back
// burst, and checks responses and interrupt lines against RAM and
// PLIC reference models
// ====================

`timescale 1ns/1ps

module tb_soc_periph;
    import soc_bus_pkg::*;

    localparam int          NUM_IRQS   = 5;
    localparam int          RAM_WORDS  = 64;
    localparam int          BURST_LEN  = 16;
    localparam logic [31:0] BURST_BASE = 32'h0000_0800;
    localparam logic [31:0] MTIME_ADDR = CLINT_BASE + 32'h10;
    localparam logic [31:0] PEND_ADDR  = PLIC_BASE;
    localparam logic [31:0] EN_ADDR    = PLIC_BASE + 32'h4;
    localparam logic [31:0] CLAIM_ADDR = PLIC_BASE + 32'h8;
    localparam string       CASE_FILE  = "testbench/bus_cases.txt";

    logic                clk;
    logic                rst_i;
    logic                req_valid_i;
    bus_req_t            req_i;
    logic [NUM_IRQS-1:0] irq_i;
    logic                resp_valid_o;
    bus_resp_t           resp_o;
    logic                timer_irq_o;
    logic                soft_irq_o;
    logic                ext_irq_o;

    // ====================
    // Reference state
    // ====================
    logic [31:0]         ram_m [RAM_WORDS];
    bit                  ram_known [RAM_WORDS];
    logic [NUM_IRQS-1:0] pend_m;
    logic [NUM_IRQS-1:0] en_m;
    bus_resp_t           exp_q [$];
    integer              seed;
    logic [31:0]         last_mtime;
    bit                  have_mtime;

    soc_periph_top dut_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .irq_i        (irq_i),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o),
        .timer_irq_o  (timer_irq_o),
        .soft_irq_o   (soft_irq_o),
        .ext_irq_o    (ext_irq_o)
    );

    // 8 ns period
    always #4 clk = ~clk;

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    // Word slot with aliasing
    function automatic int ram_index(input logic [31:0] addr);
        return int'((addr >> 2) % RAM_WORDS);
    endfunction

    // Lowest pending and enabled source gives index plus one
    function automatic logic [31:0] model_claim();
        for (int i = 0; i < NUM_IRQS; i++) begin
            if (pend_m[i] && en_m[i]) begin
                return 32'(i + 1);
            end
        end
        return 32'd0;
    endfunction

    // Counts case lines and skips comments
    function automatic int count_case_lines();
        int    fd;
        int    n;
        int    code;
        string line;
        n  = 0;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            return 0;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code != 0 && line.len() > 0 && line.getc(0) != "#") begin
                n++;
            end
        end
        $fclose(fd);
        return n;
    endfunction

    // One request and the wait for its response strobe
    task automatic bus_access(input bit is_wr, input logic [31:0] addr,
                              input logic [31:0] wdata, output bus_resp_t resp);
        @(posedge clk);
        req_valid_i <= 1'b1;
        req_i.op    <= is_wr ? BUS_WRITE : BUS_READ;
        req_i.addr  <= addr;
        req_i.wdata <= wdata;
        @(posedge clk);
        req_valid_i <= 1'b0;
        @(negedge clk);
        while (!resp_valid_o) begin
            @(negedge clk);
        end
        resp = resp_o;
    endtask

    // ====================
    // Directed bus case
    // ====================
    task automatic run_bus_case(input bit is_wr, input logic [31:0] addr,
                                input logic [31:0] wdata, input logic [31:0] exp,
                                input logic [31:0] mask, input logic exp_err);
        bus_resp_t   resp;
        logic [31:0] model;
        int          idx;
        int          k;
        idx = ram_index(addr);
        bus_access(is_wr, addr, wdata, resp);
        assert ((resp.rdata & mask) == (exp & mask)) else
            fail_stop($sformatf("Mismatch resp_o.rdata at 0x%08h: got 0x%08h expected 0x%08h",
                                addr, resp.rdata, exp));
        assert (resp.err == exp_err) else
            fail_stop($sformatf("Mismatch resp_o.err at 0x%08h: got 0x%0h expected 0x%0h",
                                addr, resp.err, exp_err));
        // RAM model
        if (addr <= RAM_LAST) begin
            if (is_wr) begin
                ram_m[idx]     = wdata;
                ram_known[idx] = 1'b1;
            end else if (ram_known[idx]) begin
                assert (resp.rdata == ram_m[idx]) else
                    fail_stop($sformatf(
                        "Mismatch resp_o.rdata at 0x%08h: got 0x%08h RAM model 0x%08h",
                        addr, resp.rdata, ram_m[idx]));
            end
        end
        // mtime keeps counting
        if (!is_wr && addr == MTIME_ADDR) begin
            if (have_mtime) begin
                assert (resp.rdata > last_mtime) else
                    fail_stop($sformatf("mtime did not advance: 0x%08h after 0x%08h",
                                        resp.rdata, last_mtime));
            end
            last_mtime = resp.rdata;
            have_mtime = 1'b1;
        end
        // PLIC model
        if (is_wr && addr == EN_ADDR) begin
            en_m = wdata[NUM_IRQS-1:0];
        end
        if (!is_wr && addr == PEND_ADDR) begin
            assert (resp.rdata == 32'(pend_m)) else
                fail_stop($sformatf(
                    "Mismatch resp_o.rdata for PLIC pending: got 0x%08h model 0x%08h",
                    resp.rdata, 32'(pend_m)));
        end
        if (!is_wr && addr == CLAIM_ADDR) begin
            model = model_claim();
            assert (resp.rdata == model) else
                fail_stop($sformatf(
                    "Mismatch resp_o.rdata for PLIC claim: got 0x%08h model 0x%08h",
                    resp.rdata, model));
            // Source still high keeps its bit
            if (model != 32'd0) begin
                k         = int'(model) - 1;
                pend_m[k] = irq_i[k];
            end
        end
    endtask

    // Drive irq_i and hold it for one sampling edge
    task automatic set_irqs(input logic [31:0] value);
        @(posedge clk);
        irq_i <= value[NUM_IRQS-1:0];
        @(posedge clk);
        pend_m = pend_m | value[NUM_IRQS-1:0];
    endtask

    task automatic check_irqs(input logic t_exp, input logic s_exp, input logic e_exp);
        // Let registered outputs settle
        repeat (2) @(negedge clk);
        assert (timer_irq_o == t_exp) else
            fail_stop($sformatf("Mismatch timer_irq_o: got 0x%0h expected 0x%0h",
                                timer_irq_o, t_exp));
        assert (soft_irq_o == s_exp) else
            fail_stop($sformatf("Mismatch soft_irq_o: got 0x%0h expected 0x%0h",
                                soft_irq_o, s_exp));
        assert (ext_irq_o == e_exp) else
            fail_stop($sformatf("Mismatch ext_irq_o: got 0x%0h expected 0x%0h",
                                ext_irq_o, e_exp));
        assert (ext_irq_o == |(pend_m & en_m)) else
            fail_stop($sformatf("Mismatch ext_irq_o: got 0x%0h model 0x%0h",
                                ext_irq_o, |(pend_m & en_m)));
    endtask

    // ====================
    // Back-to-back burst
    // ====================
    task automatic run_burst();
        logic [31:0] addr;
        logic [31:0] data;
        bus_resp_t   exp_d;
        bus_resp_t   exp_c;
        int          n_got;
        n_got = 0;
        fork
            begin
                // One request per cycle with writes before reads
                for (int i = 0; i < 2 * BURST_LEN; i++) begin
                    addr  = BURST_BASE + 32'(4 * (i % BURST_LEN));
                    exp_d = '0;
                    @(posedge clk);
                    req_valid_i <= 1'b1;
                    req_i.addr  <= addr;
                    if (i < BURST_LEN) begin
                        data                      = $random(seed);
                        req_i.op                 <= BUS_WRITE;
                        req_i.wdata              <= data;
                        ram_m[ram_index(addr)]     = data;
                        ram_known[ram_index(addr)] = 1'b1;
                    end else begin
                        req_i.op    <= BUS_READ;
                        req_i.wdata <= '0;
                        exp_d.rdata = ram_m[ram_index(addr)];
                    end
                    exp_q.push_back(exp_d);
                end
                @(posedge clk);
                req_valid_i <= 1'b0;
            end
            begin
                // In-order responses
                while (n_got < 2 * BURST_LEN) begin
                    @(negedge clk);
                    if (resp_valid_o) begin
                        assert (exp_q.size() > 0) else
                            fail_stop("A burst response arrived with no request outstanding");
                        exp_c = exp_q.pop_front();
                        assert (resp_o.rdata == exp_c.rdata) else
                            fail_stop($sformatf(
                                "Mismatch resp_o.rdata beat %0d: got 0x%08h expected 0x%08h",
                                n_got, resp_o.rdata, exp_c.rdata));
                        assert (resp_o.err == exp_c.err) else
                            fail_stop($sformatf(
                                "Mismatch resp_o.err beat %0d: got 0x%0h expected 0x%0h",
                                n_got, resp_o.err, exp_c.err));
                        n_got++;
                    end
                end
            end
        join
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        int          fd;
        int          code;
        int          n;
        string       line;
        byte         kind;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_exp;
        logic [31:0] f_mask;
        logic [31:0] f_err;
        logic [31:0] t_val;
        logic [31:0] s_val;
        logic [31:0] e_val;
        seed        = 64290;
        clk         = 1'b0;
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        irq_i       = '0;
        pend_m      = '0;
        en_m        = '0;
        last_mtime  = '0;
        have_mtime  = 1'b0;
        foreach (ram_known[i]) begin
            ram_known[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;

        fd = $fopen(CASE_FILE, "r");
        assert (fd != 0) else
            fail_stop("Could not open the case file");
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2) begin
                continue;
            end
            kind = line.getc(0);
            case (kind)
                "R", "W": begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                                f_addr, f_wdata, f_exp, f_mask, f_err);
                    assert (n == 5) else
                        fail_stop($sformatf("Malformed bus case line: %s", line));
                    run_bus_case(kind == "W", f_addr, f_wdata, f_exp, f_mask, f_err[0]);
                end
                "I": begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%h", f_addr);
                    assert (n == 1) else
                        fail_stop($sformatf("Malformed irq line: %s", line));
                    set_irqs(f_addr);
                end
                "C": begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h",
                                t_val, s_val, e_val);
                    assert (n == 3) else
                        fail_stop($sformatf("Malformed check line: %s", line));
                    check_irqs(t_val[0], s_val[0], e_val[0]);
                end
                default: begin
                    // Comment line
                end
            endcase
        end
        $fclose(fd);

        run_burst();
        $display("=== PASS ===");
        $finish;
    end

    // Watchdog allows ten cycles per case line and per burst slot
    initial begin
        int limit;
        limit = (count_case_lines() + BURST_LEN) * 10;
        repeat (limit) @(posedge clk);
        fail_stop($sformatf("Timeout: the run did not finish within %0d cycles", limit));
    end

endmodule
